//--- design/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// address and data word width
`define DCACHE_ADDR_W 32

// associativity
`define DCACHE_WAYS 2

// sets per way and words per line
`define DCACHE_SETS 64
`define DCACHE_LINE_WORDS 4

`endif

//--- design/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

    localparam int unsigned INDEX_W  = $clog2(`DCACHE_SETS);
    localparam int unsigned OFFSET_W = $clog2(`DCACHE_LINE_WORDS * (`DCACHE_ADDR_W / 8));
    localparam int unsigned TAG_W    = `DCACHE_ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset; // byte in line
    } addr_t;

    typedef logic [`DCACHE_ADDR_W-1:0] word_t;
    typedef logic [`DCACHE_LINE_WORDS-1:0][`DCACHE_ADDR_W-1:0] line_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;

    typedef enum logic [2:0] {LW, LH, LHU, LB, LBU} load_type_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        STORE_WRITE,
        WB_REQ,
        WB_WAIT,
        MISS_REQ,
        REFILL,
        REFILL_DONE
    } ctrl_state_t;

endpackage

//--- design/dcache_ctrl_if.sv
interface dcache_ctrl_if;

    logic accept;       // capture request this edge
    logic fill_en;      // write returned line into victim way
    logic store_en;     // write merged line into hit way
    logic hold_index;   // arrays use held index
    logic lookup_hit;
    logic victim_dirty;
    logic req_is_store;

    modport ctrl (
        output accept,
        output fill_en,
        output store_en,
        output hold_index,
        input  lookup_hit,
        input  victim_dirty,
        input  req_is_store
    );

    modport dp (
        input  accept,
        input  fill_en,
        input  store_en,
        input  hold_index,
        output lookup_hit,
        output victim_dirty,
        output req_is_store
    );

endinterface

//--- design/dcache_ctrl.sv
module dcache_ctrl (
    input  logic          clk,
    input  logic          reset,
    input  logic          req_valid,
    dcache_ctrl_if.ctrl   ctrl_if,
    input  logic          mem_rd_ready,
    input  logic          mem_ret_valid,
    input  logic          mem_wr_ready,
    input  logic          mem_wr_done,
    output logic          busy,
    output logic          resp_valid,
    output logic          mem_rd_req,
    output logic          mem_wr_req
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t state_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::IDLE: begin
                if (req_valid) begin
                    state_next = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (ctrl_if.lookup_hit) begin
                    state_next = ctrl_if.req_is_store ? dcache_pkg::STORE_WRITE
                                                      : dcache_pkg::IDLE;
                end else if (ctrl_if.victim_dirty) begin
                    state_next = dcache_pkg::WB_REQ; // evict first
                end else begin
                    state_next = dcache_pkg::MISS_REQ;
                end
            end
            dcache_pkg::STORE_WRITE: begin
                state_next = dcache_pkg::IDLE;
            end
            dcache_pkg::WB_REQ: begin
                if (mem_wr_ready) begin
                    state_next = dcache_pkg::WB_WAIT;
                end
            end
            dcache_pkg::WB_WAIT: begin
                if (mem_wr_done) begin
                    state_next = dcache_pkg::MISS_REQ;
                end
            end
            dcache_pkg::MISS_REQ: begin
                if (mem_rd_ready) begin
                    state_next = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REFILL: begin
                if (mem_ret_valid) begin
                    state_next = dcache_pkg::REFILL_DONE;
                end
            end
            dcache_pkg::REFILL_DONE: begin
                state_next = dcache_pkg::LOOKUP; // arrays re-read so it hits
            end
            default: begin
                state_next = dcache_pkg::IDLE;
            end
        endcase
    end

    assign busy       = (state != dcache_pkg::IDLE);
    assign resp_valid = (state == dcache_pkg::LOOKUP) && ctrl_if.lookup_hit;
    assign mem_rd_req = (state == dcache_pkg::MISS_REQ);
    assign mem_wr_req = (state == dcache_pkg::WB_REQ);

    assign ctrl_if.accept     = (state == dcache_pkg::IDLE) && req_valid;
    assign ctrl_if.hold_index = (state != dcache_pkg::IDLE);
    assign ctrl_if.store_en   = (state == dcache_pkg::STORE_WRITE);
    assign ctrl_if.fill_en    = (state == dcache_pkg::REFILL) && mem_ret_valid;

endmodule

//--- design/dcache_victim.sv
`include "dcache_cfg.svh"

module dcache_victim (
    input  logic                clk,
    input  logic                reset,
    input  dcache_pkg::index_t  index,
    input  logic                advance,
    output dcache_pkg::way_t    victim_way
);

    // one round-robin pointer per set
    dcache_pkg::way_t ptr [`DCACHE_SETS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DCACHE_SETS; i++) begin
                ptr[i] <= '0;
            end
        end else if (advance) begin
            ptr[index] <= ptr[index] + 1'b1; // wraps over the ways
        end
    end

    assign victim_way = ptr[index];

endmodule

//--- design/dcache_array.sv
`include "dcache_cfg.svh"

module dcache_array #(
    parameter type payload_t = logic
) (
    input  logic                clk,
    input  logic                we,
    input  dcache_pkg::index_t  addr,
    input  payload_t            wdata,
    output payload_t            rdata
);

    payload_t mem [`DCACHE_SETS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // old contents on a write
    end

endmodule

//--- design/dcache_datapath.sv
`include "dcache_cfg.svh"

module dcache_datapath (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_write,
    input  dcache_pkg::word_t       req_addr,
    input  logic [3:0]              req_wstrb,
    input  dcache_pkg::word_t       req_wdata,
    input  dcache_pkg::load_type_t  req_load_type,
    dcache_ctrl_if.dp               ctrl_if,
    input  dcache_pkg::way_t        victim_way,
    output dcache_pkg::index_t      req_index,
    output dcache_pkg::word_t       resp_rdata,
    output dcache_pkg::word_t       mem_rd_addr,
    output dcache_pkg::word_t       mem_wr_addr,
    output dcache_pkg::line_t       mem_wr_data,
    input  dcache_pkg::line_t       mem_ret_data
);

    dcache_pkg::addr_t      in_addr;
    dcache_pkg::addr_t      addr_q;
    logic                   write_q;
    logic [3:0]             wstrb_q;
    dcache_pkg::word_t      wdata_q;
    dcache_pkg::load_type_t load_type_q;
    dcache_pkg::index_t     arr_index;
    dcache_pkg::index_t     sweep_idx;
    logic                   sweep_run;
    logic                   wipe_en;
    logic                   clear_en;
    logic [`DCACHE_SETS-1:0] cleared;
    dcache_pkg::tagv_t      tagv_rdata [`DCACHE_WAYS];
    dcache_pkg::line_t      line_rdata [`DCACHE_WAYS];
    logic                   dirty_rdata [`DCACHE_WAYS];
    logic [`DCACHE_WAYS-1:0] hit_vec;
    dcache_pkg::way_t       hit_way;
    dcache_pkg::tagv_t      tagv_wdata;
    dcache_pkg::line_t      line_wdata;
    dcache_pkg::line_t      merged;
    dcache_pkg::word_t      hit_word;
    dcache_pkg::word_t      byte_sh;
    dcache_pkg::word_t      half_sh;
    logic [$clog2(`DCACHE_LINE_WORDS)-1:0] word_sel;

    assign in_addr = req_addr;

    always_ff @(posedge clk) begin
        if (ctrl_if.accept) begin
            addr_q      <= in_addr;
            write_q     <= req_write;
            wstrb_q     <= req_wstrb;
            wdata_q     <= req_wdata;
            load_type_q <= req_load_type;
        end
    end

    // valid sweep during reset and clearing of late sets on first lookup
    always_ff @(posedge clk) begin
        if (reset) begin
            sweep_run <= 1'b1;
            if (sweep_run) begin
                cleared[sweep_idx] <= 1'b1;
                sweep_idx          <= sweep_idx + 1'b1;
            end else begin
                cleared   <= '0;
                sweep_idx <= '0;
            end
        end else begin
            sweep_run <= 1'b0;
            if (clear_en) begin
                cleared[addr_q.index] <= 1'b1;
            end
        end
    end

    assign clear_en  = ctrl_if.hold_index && !cleared[addr_q.index];
    assign wipe_en   = (reset && sweep_run) || clear_en;
    assign arr_index = reset ? sweep_idx : (ctrl_if.hold_index ? addr_q.index : in_addr.index);

    assign tagv_wdata = ctrl_if.fill_en ? {1'b1, addr_q.tag} : '0;
    assign line_wdata = ctrl_if.fill_en ? mem_ret_data : merged;

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        logic fill_way;
        logic store_way;

        assign fill_way   = ctrl_if.fill_en && (victim_way == dcache_pkg::way_t'(w));
        assign store_way  = ctrl_if.store_en && hit_vec[w];
        assign hit_vec[w] = tagv_rdata[w].valid && (tagv_rdata[w].tag == addr_q.tag);

        dcache_array #(.payload_t(dcache_pkg::tagv_t)) u_tagv (
            .clk(clk), .we(fill_way || wipe_en), .addr(arr_index),
            .wdata(tagv_wdata), .rdata(tagv_rdata[w])
        );
        dcache_array #(.payload_t(dcache_pkg::line_t)) u_line (
            .clk(clk), .we(fill_way || store_way), .addr(arr_index),
            .wdata(line_wdata), .rdata(line_rdata[w])
        );
        dcache_array #(.payload_t(logic)) u_dirty (
            .clk(clk), .we(fill_way || store_way || wipe_en), .addr(arr_index),
            .wdata(ctrl_if.store_en), .rdata(dirty_rdata[w])
        );
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign ctrl_if.lookup_hit   = cleared[addr_q.index] && (|hit_vec);
    assign ctrl_if.victim_dirty = cleared[addr_q.index] && dirty_rdata[victim_way];
    assign ctrl_if.req_is_store = write_q;

    assign word_sel = addr_q.offset[dcache_pkg::OFFSET_W-1:2];
    assign hit_word = line_rdata[hit_way][word_sel];

    always_comb begin
        merged = line_rdata[hit_way];
        for (int b = 0; b < 4; b++) begin
            if (wstrb_q[b]) begin
                merged[word_sel][b*8 +: 8] = wdata_q[b*8 +: 8];
            end
        end
    end

    assign byte_sh = hit_word >> {addr_q.offset[1:0], 3'b000};
    assign half_sh = hit_word >> {addr_q.offset[1], 4'b0000};

    always_comb begin
        case (load_type_q)
            dcache_pkg::LH:  resp_rdata = {{16{half_sh[15]}}, half_sh[15:0]};
            dcache_pkg::LHU: resp_rdata = {16'b0, half_sh[15:0]};
            dcache_pkg::LB:  resp_rdata = {{24{byte_sh[7]}}, byte_sh[7:0]};
            dcache_pkg::LBU: resp_rdata = {24'b0, byte_sh[7:0]};
            default:         resp_rdata = hit_word; // LW
        endcase
    end

    assign req_index   = addr_q.index;
    assign mem_rd_addr = {addr_q.tag, addr_q.index, {dcache_pkg::OFFSET_W{1'b0}}};
    assign mem_wr_addr = {tagv_rdata[victim_way].tag, addr_q.index,
                          {dcache_pkg::OFFSET_W{1'b0}}};
    assign mem_wr_data = line_rdata[victim_way];

endmodule

//--- design/dcache_top.sv
module dcache_top (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req_valid,
    input  logic                    req_write,
    input  dcache_pkg::word_t       req_addr,
    input  logic [3:0]              req_wstrb,
    input  dcache_pkg::word_t       req_wdata,
    input  dcache_pkg::load_type_t  req_load_type,
    output logic                    busy,
    output logic                    resp_valid,
    output dcache_pkg::word_t       resp_rdata,
    output logic                    mem_rd_req,
    output dcache_pkg::word_t       mem_rd_addr,
    input  logic                    mem_rd_ready,
    input  logic                    mem_ret_valid,
    input  dcache_pkg::line_t       mem_ret_data,
    output logic                    mem_wr_req,
    output dcache_pkg::word_t       mem_wr_addr,
    output dcache_pkg::line_t       mem_wr_data,
    input  logic                    mem_wr_ready,
    input  logic                    mem_wr_done
);

    dcache_pkg::way_t   victim_way;
    dcache_pkg::index_t req_index;

    dcache_ctrl_if u_ctrl_if ();

    dcache_ctrl u_ctrl (
        .clk(clk), .reset(reset), .req_valid(req_valid), .ctrl_if(u_ctrl_if.ctrl),
        .mem_rd_ready(mem_rd_ready), .mem_ret_valid(mem_ret_valid),
        .mem_wr_ready(mem_wr_ready), .mem_wr_done(mem_wr_done),
        .busy(busy), .resp_valid(resp_valid),
        .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req)
    );

    dcache_victim u_victim (
        .clk(clk), .reset(reset), .index(req_index),
        .advance(u_ctrl_if.fill_en), .victim_way(victim_way)
    );

    dcache_datapath u_datapath (
        .clk(clk), .reset(reset),
        .req_write(req_write), .req_addr(req_addr), .req_wstrb(req_wstrb),
        .req_wdata(req_wdata), .req_load_type(req_load_type),
        .ctrl_if(u_ctrl_if.dp), .victim_way(victim_way), .req_index(req_index),
        .resp_rdata(resp_rdata), .mem_rd_addr(mem_rd_addr),
        .mem_wr_addr(mem_wr_addr), .mem_wr_data(mem_wr_data),
        .mem_ret_data(mem_ret_data)
    );

endmodule

//--- sim/dcache_mem_model.sv
module dcache_mem_model (
    input  logic              clk,
    input  logic              mem_rd_req,
    input  dcache_pkg::word_t mem_rd_addr,
    output logic              mem_rd_ready,
    output logic              mem_ret_valid,
    output dcache_pkg::line_t mem_ret_data,
    input  logic              mem_wr_req,
    input  dcache_pkg::word_t mem_wr_addr,
    input  dcache_pkg::line_t mem_wr_data,
    output logic              mem_wr_ready,
    output logic              mem_wr_done
);

    integer seed = 80;
    dcache_pkg::line_t lines [256]; // one entry per line of a 4 KB window

    task automatic random_wait();
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n) @(posedge clk);
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            for (int w = 0; w < 4; w++) begin
                lines[i][w] = ~dcache_pkg::word_t'(i * 16 + w * 4);
            end
        end
        mem_rd_ready  = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_data  = '0;
        mem_wr_ready  = 1'b0;
        mem_wr_done   = 1'b0;
        forever begin
            @(posedge clk);
            if (mem_wr_req === 1'b1) begin
                lines[mem_wr_addr[11:4]] = mem_wr_data; // whole line written back
                random_wait();
                mem_wr_ready <= 1'b1;
                @(posedge clk);
                mem_wr_ready <= 1'b0;
                random_wait();
                mem_wr_done <= 1'b1;
                @(posedge clk);
                mem_wr_done <= 1'b0;
            end else if (mem_rd_req === 1'b1) begin
                random_wait();
                mem_rd_ready <= 1'b1;
                @(posedge clk);
                mem_rd_ready <= 1'b0;
                random_wait();
                mem_ret_valid <= 1'b1;
                mem_ret_data  <= lines[mem_rd_addr[11:4]];
                @(posedge clk);
                mem_ret_valid <= 1'b0;
            end
        end
    end

endmodule

//--- sim/dcache_tb.sv
module dcache_tb;

    localparam int N_REQ       = 221; // 21 directed plus 200 random
    localparam int CYCLE_LIMIT = 40 * N_REQ;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   req_valid;
    logic                   req_write;
    dcache_pkg::word_t      req_addr;
    logic [3:0]             req_wstrb;
    dcache_pkg::word_t      req_wdata;
    dcache_pkg::load_type_t req_load_type;
    logic                   busy;
    logic                   resp_valid;
    dcache_pkg::word_t      resp_rdata;
    logic                   mem_rd_req;
    dcache_pkg::word_t      mem_rd_addr;
    logic                   mem_rd_ready;
    logic                   mem_ret_valid;
    dcache_pkg::line_t      mem_ret_data;
    logic                   mem_wr_req;
    dcache_pkg::word_t      mem_wr_addr;
    dcache_pkg::line_t      mem_wr_data;
    logic                   mem_wr_ready;
    logic                   mem_wr_done;

    integer            seed = 80;
    int                cycles = 0;
    int                errors = 0;
    int                tests = 0;
    int                err_start = 0;
    int                wb_count = 0;
    int                wb_before;
    string             test_name;
    dcache_pkg::word_t ref_mem [1024]; // word view of the 4 KB test window
    dcache_pkg::word_t exp_rdata = '0;
    dcache_pkg::word_t cur_addr = '0;
    dcache_pkg::word_t wb_addr = '0;
    logic              cur_write = 1'b0;
    logic              hit_expect = 1'b0;
    logic              wb_expect = 1'b0;

    dcache_top u_dcache_top (.*);
    dcache_mem_model u_mem_model (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (mem_wr_req && mem_wr_ready) begin
            wb_count <= wb_count + 1;
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic dcache_pkg::line_t ref_line(input dcache_pkg::word_t addr);
        for (int w = 0; w < 4; w++) begin
            ref_line[w] = ref_mem[{addr[11:4], w[1:0]}];
        end
    endfunction

    function automatic dcache_pkg::word_t extend_load(input dcache_pkg::word_t w,
                                                      input logic [1:0] lo,
                                                      input dcache_pkg::load_type_t lt);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[{lo, 3'b000} +: 8];
        h = lo[1] ? w[31:16] : w[15:0];
        case (lt)
            dcache_pkg::LB:  extend_load = {{24{b[7]}}, b};
            dcache_pkg::LBU: extend_load = {24'd0, b};
            dcache_pkg::LH:  extend_load = {{16{h[15]}}, h};
            dcache_pkg::LHU: extend_load = {16'd0, h};
            default:         extend_load = w;
        endcase
    endfunction

    assert property (@(posedge clk) $fell(reset) |->
                     !busy && !resp_valid && !mem_rd_req && !mem_wr_req)
        else begin
            $display("reset: busy, resp_valid or a memory request is high after reset");
            errors++;
        end

    assert property (@(posedge clk) disable iff (reset)
                     resp_valid && !cur_write |-> resp_rdata == exp_rdata)
        else begin
            $display("FAIL %s expected %h actual %h", test_name,
                     $sampled(exp_rdata), $sampled(resp_rdata));
            errors++;
        end

    assert property (@(posedge clk) disable iff (reset)
                     $rose(mem_rd_req) |-> mem_rd_addr == {cur_addr[31:4], 4'b0000})
        else begin
            $display("FAIL %s expected %h actual %h", test_name,
                     {cur_addr[31:4], 4'b0000}, $sampled(mem_rd_addr));
            errors++;
        end

    assert property (@(posedge clk) disable iff (reset)
                     $rose(mem_wr_req) |-> mem_wr_data == ref_line(mem_wr_addr))
        else begin
            $display("FAIL %s expected %h actual %h", test_name,
                     ref_line($sampled(mem_wr_addr)), $sampled(mem_wr_data));
            errors++;
        end

    assert property (@(posedge clk) disable iff (reset)
                     $rose(mem_wr_req) && wb_expect |-> mem_wr_addr == wb_addr)
        else begin
            $display("FAIL %s expected %h actual %h", test_name, wb_addr,
                     $sampled(mem_wr_addr));
            errors++;
        end

    assert property (@(posedge clk) disable iff (reset)
                     req_valid && !busy && hit_expect |=> resp_valid)
        else begin
            $display("%s: no response one cycle after acceptance", test_name);
            errors++;
        end

    assert property (@(posedge clk) disable iff (reset)
                     hit_expect |-> !mem_rd_req && !mem_wr_req)
        else begin
            $display("%s: memory request during a hit", test_name);
            errors++;
        end

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic close_test();
        tests++;
        $display("test %-12s %0d errors", test_name, errors - err_start);
    endtask

    task automatic apply_store(input dcache_pkg::word_t addr, input logic [3:0] strb,
                               input dcache_pkg::word_t wdata);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                ref_mem[addr[11:2]][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    endtask

    // one request up to its response pulse
    task automatic issue(input logic wr, input dcache_pkg::word_t addr, input logic [3:0] strb,
                         input dcache_pkg::word_t wdata, input dcache_pkg::load_type_t lt);
        @(posedge clk);
        while (busy) @(posedge clk);
        cur_write = wr;
        cur_addr  = addr;
        if (wr) begin
            apply_store(addr, strb, wdata);
        end else begin
            exp_rdata = extend_load(ref_mem[addr[11:2]], addr[1:0], lt);
        end
        req_valid     <= 1'b1;
        req_write     <= wr;
        req_addr      <= addr;
        req_wstrb     <= strb;
        req_wdata     <= wdata;
        req_load_type <= lt;
        @(posedge clk);
        req_valid <= 1'b0;
        do @(posedge clk); while (!resp_valid);
    endtask

    task automatic run_random(input int count);
        logic [31:0]            r;
        dcache_pkg::word_t      addr;
        dcache_pkg::load_type_t lt;
        for (int n = 0; n < count; n++) begin
            r    = $random(seed);
            lt   = dcache_pkg::load_type_t'(r[9:7] % 3'd5);
            addr = {20'd0, r[1:0], 3'd0, r[4:2], r[6:5], 2'b00}; // 4 tags over 8 sets
            if (lt == dcache_pkg::LH || lt == dcache_pkg::LHU) begin
                addr[1] = r[10];
            end else if (lt == dcache_pkg::LB || lt == dcache_pkg::LBU) begin
                addr[1:0] = r[11:10];
            end
            issue(r[12], addr, r[16:13], $random(seed), lt);
        end
    endtask

    initial begin
        reset         = 1'b1;
        req_valid     = 1'b0;
        req_write     = 1'b0;
        req_addr      = '0;
        req_wstrb     = '0;
        req_wdata     = '0;
        req_load_type = dcache_pkg::LW;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = ~dcache_pkg::word_t'(i * 4);
        end

        start_test("reset");
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        close_test();

        start_test("cold_miss");
        issue(1'b0, 32'h7f8, 4'h0, '0, dcache_pkg::LW);
        close_test();

        start_test("load_types");
        for (int o = 0; o < 4; o++) begin
            issue(1'b0, 32'h7f8 + o, 4'h0, '0, dcache_pkg::LB);
            issue(1'b0, 32'h7f8 + o, 4'h0, '0, dcache_pkg::LBU);
            if (o[0] == 1'b0) begin
                issue(1'b0, 32'h7f8 + o, 4'h0, '0, dcache_pkg::LH);
                issue(1'b0, 32'h7f8 + o, 4'h0, '0, dcache_pkg::LHU);
            end
        end
        issue(1'b0, 32'h7f8, 4'h0, '0, dcache_pkg::LW);
        close_test();

        start_test("store_hit");
        issue(1'b0, 32'h220, 4'h0, '0, dcache_pkg::LW); // bring the line in
        hit_expect = 1'b1;
        issue(1'b1, 32'h224, 4'b0110, 32'ha5c3_5a3c, dcache_pkg::LW);
        issue(1'b0, 32'h224, 4'h0, '0, dcache_pkg::LW);
        hit_expect = 1'b0;
        close_test();

        start_test("eviction");
        issue(1'b1, 32'h054, 4'hf, 32'h1234_5678, dcache_pkg::LW);
        issue(1'b0, 32'h450, 4'h0, '0, dcache_pkg::LW);
        wb_before = wb_count;
        wb_addr   = 32'h050;
        wb_expect = 1'b1;
        issue(1'b0, 32'h850, 4'h0, '0, dcache_pkg::LW); // third tag in set 5
        wb_expect = 1'b0;
        assert (wb_count != wb_before)
            else begin
                $display("eviction: the dirty line was not written back");
                errors++;
            end
        issue(1'b0, 32'h054, 4'h0, '0, dcache_pkg::LW);
        close_test();

        start_test("random");
        run_random(200);
        close_test();

        $display("tests %0d, errors %0d, cycles %0d", tests, errors, cycles);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- dcache.f
+incdir+design
design/dcache_pkg.sv
design/dcache_ctrl_if.sv
design/dcache_ctrl.sv
design/dcache_victim.sv
design/dcache_array.sv
design/dcache_datapath.sv
design/dcache_top.sv
sim/dcache_mem_model.sv
sim/dcache_tb.sv
